//--- rtl/perint_soc_pkg.sv
/* perint_soc shared definitions: bus widths, request and response structs,
   device slots with their map entries, and the software reset codes */
package perint_soc_pkg;

	localparam int ARCH_W = 32;
	localparam int ADDR_W = 30;
	localparam int SEL_W  = 4;

	// Bus operation codes, same encoding as the PerInt op field
	typedef enum logic [1:0] {
		PI_NOP   = 2'd0,
		PI_WRITE = 2'd1,
		PI_READ  = 2'd2
	} pi_op_e;

	typedef struct packed {
		pi_op_e              op;
		logic [ADDR_W-1:0]   addr;
		logic [ARCH_W-1:0]   data;
		logic [SEL_W-1:0]    sel;
	} pi_req_t;

	typedef struct packed {
		logic                rdy;
		logic [ARCH_W-1:0]   data;
	} pi_rsp_t;

	// Slots in map order, the last one catches every unmapped address
	typedef enum logic [1:0] {
		SLOT_DEVTBL  = 2'd0,
		SLOT_INTCTRL = 2'd1,
		SLOT_RAM     = 2'd2,
		SLOT_INVALID = 2'd3
	} slot_e;

	localparam int SLOT_CNT = 4;

	// One device table word, mapsz counts words
	typedef struct packed {
		logic          useintr;
		logic [14:0]   id;
		logic [15:0]   mapsz;
	} dev_entry_t;

	localparam dev_entry_t DEV_MAP [SLOT_CNT] = '{
		'{useintr: 1'b0, id: 15'd7, mapsz: 16'd16},
		'{useintr: 1'b0, id: 15'd3, mapsz: 16'd16},
		'{useintr: 1'b0, id: 15'd1, mapsz: 16'd64},
		'{useintr: 1'b0, id: 15'd0, mapsz: 16'd0}
	};

	localparam int RAM_WORDS = 64;

	localparam int INT_SRC_CNT = 2;
	localparam logic [ARCH_W-1:0] INT_NONE = '1;

	typedef enum logic [1:0] {
		SWRST_NONE   = 2'd0,
		SWRST_WARM   = 2'd1,
		SWRST_PWROFF = 2'd2
	} swrst_e;

endpackage

//--- rtl/reset_seq.sv
/* Reset sequencer: countdown after external or warm reset, plus a power-off
   latch that holds the SoC in reset until the next external reset */
`timescale 1ns/1ps

module reset_seq import perint_soc_pkg::*; #(
	parameter int RST_CNTR_W = 16
) (
	input  logic   clk24mhz,
	input  logic   rst_p,
	input  swrst_e swrst_i,
	output logic   soc_rst_o
);

	logic [RST_CNTR_W-1:0] rst_cntr_q;
	logic                  pwroff_q;

	// Reload on external or warm reset, otherwise count down to zero
	always_ff @(posedge clk24mhz) begin
		if (rst_p || swrst_i == SWRST_WARM) begin
			rst_cntr_q <= '1;
		end else if (rst_cntr_q != '0) begin
			rst_cntr_q <= rst_cntr_q - 1'b1;
		end
	end

	// Power-off sticks until the board reset is pressed again
	always_ff @(posedge clk24mhz) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (swrst_i == SWRST_PWROFF) begin
			pwroff_q <= 1'b1;
		end
	end

	assign soc_rst_o = (rst_cntr_q != '0) || pwroff_q;

	// Power-off request puts the SoC in reset and the latch keeps it there
	a_pwroff_holds: assert property (@(posedge clk24mhz) disable iff (rst_p)
		(swrst_i == SWRST_PWROFF || pwroff_q) |=> soc_rst_o);

	// Counter stays at zero until some reset source shows up
	a_stays_released: assert property (@(posedge clk24mhz) disable iff (rst_p)
		(!soc_rst_o && swrst_i == SWRST_NONE) |=> !soc_rst_o);

endmodule

//--- rtl/pi_router.sv
/* Bus router: decodes word addresses against the device map, forwards the
   request to one slot and steers the returned read word back to the master */
`timescale 1ns/1ps

module pi_router import perint_soc_pkg::*; (
	input  logic              clk24mhz,
	input  logic              soc_rst_i,
	input  pi_req_t           pi_req_i,
	output pi_rsp_t           pi_rsp_o,
	output pi_req_t           devtbl_req_o,
	output pi_req_t           intctrl_req_o,
	output pi_req_t           ram_req_o,
	input  logic [ARCH_W-1:0] devtbl_data_i,
	input  logic [ARCH_W-1:0] intctrl_data_i,
	input  logic [ARCH_W-1:0] ram_data_i
);

	// Slots sit back to back from word 0
	localparam logic [ADDR_W-1:0] BASE_DEVTBL  = '0;
	localparam logic [ADDR_W-1:0] BASE_INTCTRL =
		BASE_DEVTBL + ADDR_W'(DEV_MAP[SLOT_DEVTBL].mapsz);
	localparam logic [ADDR_W-1:0] BASE_RAM =
		BASE_INTCTRL + ADDR_W'(DEV_MAP[SLOT_INTCTRL].mapsz);
	localparam logic [ADDR_W-1:0] MAP_END =
		BASE_RAM + ADDR_W'(DEV_MAP[SLOT_RAM].mapsz);

	slot_e slot;
	slot_e rd_slot_q;
	logic  rdy;
	logic  accept;

	// Offset within the slot, op dropped unless this slot takes the request
	function automatic pi_req_t fwd(input pi_req_t req, input slot_e sel_slot,
		input logic acc, input slot_e dev, input logic [ADDR_W-1:0] base);
		pi_req_t r;
		r = req;
		r.addr = req.addr - base;
		if (!(acc && sel_slot == dev)) begin
			r.op = PI_NOP;
		end
		return r;
	endfunction

	always_comb begin
		if (pi_req_i.addr < BASE_INTCTRL) begin
			slot = SLOT_DEVTBL;
		end else if (pi_req_i.addr < BASE_RAM) begin
			slot = SLOT_INTCTRL;
		end else if (pi_req_i.addr < MAP_END) begin
			slot = SLOT_RAM;
		end else begin
			slot = SLOT_INVALID;
		end
	end

	assign rdy    = !soc_rst_i;
	assign accept = rdy && (pi_req_i.op != PI_NOP);

	assign devtbl_req_o  = fwd(pi_req_i, slot, accept, SLOT_DEVTBL, BASE_DEVTBL);
	assign intctrl_req_o = fwd(pi_req_i, slot, accept, SLOT_INTCTRL, BASE_INTCTRL);
	assign ram_req_o     = fwd(pi_req_i, slot, accept, SLOT_RAM, BASE_RAM);

	// Tag of the read in flight, anything else returns zero next cycle
	always_ff @(posedge clk24mhz) begin
		if (soc_rst_i) begin
			rd_slot_q <= SLOT_INVALID;
		end else if (accept && pi_req_i.op == PI_READ) begin
			rd_slot_q <= slot;
		end else begin
			rd_slot_q <= SLOT_INVALID;
		end
	end

	always_comb begin
		pi_rsp_o.rdy = rdy;
		case (rd_slot_q)
			SLOT_DEVTBL:  pi_rsp_o.data = devtbl_data_i;
			SLOT_INTCTRL: pi_rsp_o.data = intctrl_data_i;
			SLOT_RAM:     pi_rsp_o.data = ram_data_i;
			default:      pi_rsp_o.data = '0;
		endcase
	end

	// Master must hold a stalled request unchanged
	a_req_held: assert property (@(posedge clk24mhz)
		(pi_req_i.op != PI_NOP && !rdy) |=> $stable(pi_req_i));

endmodule

//--- rtl/dev_table.sv
/* Device table: read-only map entries for each slot and the software reset
   control register */
`timescale 1ns/1ps

module dev_table import perint_soc_pkg::*; (
	input  logic              clk24mhz,
	input  logic              soc_rst_i,
	input  pi_req_t           req_i,
	output logic [ARCH_W-1:0] data_o,
	output swrst_e            swrst_o
);

	// Control register sits right after the map entries
	localparam logic [ADDR_W-1:0] CTRL_OFS = ADDR_W'(SLOT_CNT);

	logic [ARCH_W-1:0] rd_word;
	logic [ARCH_W-1:0] data_q;
	swrst_e            swrst_q;

	always_comb begin
		if (req_i.addr < CTRL_OFS) begin
			rd_word = DEV_MAP[slot_e'(req_i.addr[$bits(slot_e)-1:0])];
		end else begin
			rd_word = '0;
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (req_i.op == PI_READ) begin
			data_q <= rd_word;
		end
	end

	// Reset code is a single cycle pulse towards the sequencer
	always_ff @(posedge clk24mhz) begin
		if (soc_rst_i) begin
			swrst_q <= SWRST_NONE;
		end else if (req_i.op == PI_WRITE && req_i.addr == CTRL_OFS) begin
			swrst_q <= swrst_e'(req_i.data[1:0]);
		end else begin
			swrst_q <= SWRST_NONE;
		end
	end

	assign data_o  = data_q;
	assign swrst_o = swrst_q;

endmodule

//--- rtl/int_ctrl.sv
/* Interrupt controller: pending and enable registers, level request output
   and claim of the lowest enabled pending source by a read */
`timescale 1ns/1ps

module int_ctrl import perint_soc_pkg::*; (
	input  logic                   clk24mhz,
	input  logic                   soc_rst_i,
	input  pi_req_t                req_i,
	output logic [ARCH_W-1:0]      data_o,
	input  logic [INT_SRC_CNT-1:0] irq_src_i,
	output logic                   irq_o
);

	localparam int IDX_W = (INT_SRC_CNT > 1) ? $clog2(INT_SRC_CNT) : 1;

	localparam logic [ADDR_W-1:0] CLAIM_OFS  = ADDR_W'(0);
	localparam logic [ADDR_W-1:0] ENABLE_OFS = ADDR_W'(1);

	logic [INT_SRC_CNT-1:0] pending_q;
	logic [INT_SRC_CNT-1:0] enable_q;
	logic [INT_SRC_CNT-1:0] active;
	logic [INT_SRC_CNT-1:0] clr_mask;
	logic [IDX_W-1:0]       claim_idx;
	logic                   claim_hit;
	logic                   claim;
	logic [ARCH_W-1:0]      data_q;

	assign active = pending_q & enable_q;
	assign claim  = (req_i.op == PI_READ) && (req_i.addr == CLAIM_OFS);

	// Scan from the top so the lowest index wins
	always_comb begin
		claim_hit = 1'b0;
		claim_idx = '0;
		for (int i = INT_SRC_CNT - 1; i >= 0; i--) begin
			if (active[i]) begin
				claim_hit = 1'b1;
				claim_idx = IDX_W'(i);
			end
		end
	end

	always_comb begin
		clr_mask = '0;
		if (claim && claim_hit) begin
			clr_mask[claim_idx] = 1'b1;
		end
	end

	// New pulse wins over a claim of the same source
	always_ff @(posedge clk24mhz) begin
		if (soc_rst_i) begin
			pending_q <= '0;
			enable_q  <= '0;
		end else begin
			pending_q <= (pending_q & ~clr_mask) | irq_src_i;
			if (req_i.op == PI_WRITE && req_i.addr == ENABLE_OFS) begin
				enable_q <= req_i.data[INT_SRC_CNT-1:0];
			end
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (claim) begin
			data_q <= claim_hit ? ARCH_W'(claim_idx) : INT_NONE;
		end else if (req_i.op == PI_READ && req_i.addr == ENABLE_OFS) begin
			data_q <= ARCH_W'(enable_q);
		end else if (req_i.op == PI_READ) begin
			data_q <= '0;
		end
	end

	assign data_o = data_q;
	assign irq_o  = |active;

	// Claimed index is a real source whose pending bit is gone unless it fired again
	a_claim_idx: assert property (@(posedge clk24mhz) disable iff (soc_rst_i)
		(claim && claim_hit) |=> (data_o < ARCH_W'(INT_SRC_CNT)
			&& (pending_q & $past(clr_mask & ~irq_src_i)) == '0));

endmodule

//--- rtl/scratch_ram.sv
/* Scratch RAM: word memory with per-byte write enables and registered reads */
`timescale 1ns/1ps

module scratch_ram import perint_soc_pkg::*; (
	input  logic              clk24mhz,
	input  pi_req_t           req_i,
	output logic [ARCH_W-1:0] data_o
);

	localparam int RAM_AW = $clog2(RAM_WORDS);

	logic [ARCH_W-1:0] mem [RAM_WORDS];
	logic [RAM_AW-1:0] idx;
	logic [ARCH_W-1:0] data_q;

	// Router only forwards offsets inside the RAM slot
	assign idx = req_i.addr[RAM_AW-1:0];

	always_ff @(posedge clk24mhz) begin
		if (req_i.op == PI_WRITE) begin
			for (int b = 0; b < SEL_W; b++) begin
				if (req_i.sel[b]) begin
					mem[idx][b*8 +: 8] <= req_i.data[b*8 +: 8];
				end
			end
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (req_i.op == PI_READ) begin
			data_q <= mem[idx];
		end
	end

	assign data_o = data_q;

endmodule

//--- rtl/perint_soc.sv
/* perint_soc top level: reset sequencer, bus router and the three devices
   running on the single 24 MHz clock */
`timescale 1ns/1ps

module perint_soc import perint_soc_pkg::*; #(
	parameter int RST_CNTR_W = 16
) (
	input  logic                   clk24mhz,
	input  logic                   rst_p,
	input  pi_req_t                pi_req_i,
	output pi_rsp_t                pi_rsp_o,
	input  logic [INT_SRC_CNT-1:0] irq_src_i,
	output logic                   irq_o,
	output logic                   soc_rst_o
);

	logic                soc_rst;
	swrst_e              swrst;

	pi_req_t             devtbl_req;
	pi_req_t             intctrl_req;
	pi_req_t             ram_req;

	logic [ARCH_W-1:0]   devtbl_data;
	logic [ARCH_W-1:0]   intctrl_data;
	logic [ARCH_W-1:0]   ram_data;

	assign soc_rst_o = soc_rst;

	reset_seq #(
		.RST_CNTR_W (RST_CNTR_W)
	) reset_seq_i (
		.clk24mhz  (clk24mhz),
		.rst_p     (rst_p),
		.swrst_i   (swrst),
		.soc_rst_o (soc_rst)
	);

	pi_router pi_router_i (
		.clk24mhz       (clk24mhz),
		.soc_rst_i      (soc_rst),
		.pi_req_i       (pi_req_i),
		.pi_rsp_o       (pi_rsp_o),
		.devtbl_req_o   (devtbl_req),
		.intctrl_req_o  (intctrl_req),
		.ram_req_o      (ram_req),
		.devtbl_data_i  (devtbl_data),
		.intctrl_data_i (intctrl_data),
		.ram_data_i     (ram_data)
	);

	dev_table dev_table_i (
		.clk24mhz  (clk24mhz),
		.soc_rst_i (soc_rst),
		.req_i     (devtbl_req),
		.data_o    (devtbl_data),
		.swrst_o   (swrst)
	);

	int_ctrl int_ctrl_i (
		.clk24mhz  (clk24mhz),
		.soc_rst_i (soc_rst),
		.req_i     (intctrl_req),
		.data_o    (intctrl_data),
		.irq_src_i (irq_src_i),
		.irq_o     (irq_o)
	);

	// RAM keeps its contents across every reset
	scratch_ram scratch_ram_i (
		.clk24mhz (clk24mhz),
		.req_i    (ram_req),
		.data_o   (ram_data)
	);

endmodule

//--- verification/perint_soc_tb.sv
/* perint_soc testbench: directed tests for reset timing, device table, RAM,
   invalid device, interrupt claims and software reset */
`timescale 1ns/1ps

module perint_soc_tb import perint_soc_pkg::*;;

	localparam int RST_W = 4;
	localparam int RST_CYCLES = (1 << RST_W) - 1;
	localparam int TEST_CNT = 6;
	// Word bases of the device map
	localparam logic [ADDR_W-1:0] INTC_BASE = 30'd16;
	localparam logic [ADDR_W-1:0] RAM_BASE = 30'd32;
	localparam logic [ADDR_W-1:0] MAP_END = 30'd96;
	localparam logic [ADDR_W-1:0] CTRL_ADDR = 30'd4;

	logic                   clk24mhz;
	logic                   rst_p;
	pi_req_t                pi_req;
	pi_rsp_t                pi_rsp;
	logic [INT_SRC_CNT-1:0] irq_src;
	logic                   irq;
	logic                   soc_rst;

	logic [31:0]       lcg_state;
	logic [ARCH_W-1:0] ram_model [RAM_WORDS];

	perint_soc #(
		.RST_CNTR_W (RST_W)
	) perint_soc_i (
		.clk24mhz  (clk24mhz),
		.rst_p     (rst_p),
		.pi_req_i  (pi_req),
		.pi_rsp_o  (pi_rsp),
		.irq_src_i (irq_src),
		.irq_o     (irq),
		.soc_rst_o (soc_rst)
	);

	initial clk24mhz = 1'b0;
	always #2 clk24mhz = ~clk24mhz;

	initial begin
		repeat (TEST_CNT * 400 + 200) @(posedge clk24mhz);
		$display("watchdog expired, a test did not finish in time");
		$display("TESTBENCH FAILED");
		$fatal(1);
	end

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	// Map entries as listed in the device map
	function automatic dev_entry_t expected_entry(input int k);
		case (k)
			0: return '{useintr: 1'b0, id: 15'd7, mapsz: 16'd16};
			1: return '{useintr: 1'b0, id: 15'd3, mapsz: 16'd16};
			2: return '{useintr: 1'b0, id: 15'd1, mapsz: 16'd64};
			default: return '{useintr: 1'b0, id: 15'd0, mapsz: 16'd0};
		endcase
	endfunction

	task automatic check_word(input string name, input logic [ARCH_W-1:0] exp,
		input logic [ARCH_W-1:0] act);
		if (act !== exp) begin
			$display("mismatch %s expected %08h actual %08h", name, exp, act);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_entry(input string name, input dev_entry_t exp,
		input dev_entry_t act);
		if (act !== exp) begin
			$display("mismatch %s expected %08h actual %08h", name, exp, act);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch %s expected %b actual %b", name, exp, act);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	// Inputs change just after the rising edge
	task automatic next_cycle();
		@(posedge clk24mhz);
		#0.5;
	endtask

	task automatic wait_accept();
		int  waited;
		logic acc;
		waited = 0;
		acc = 1'b0;
		while (!acc) begin
			acc = pi_rsp.rdy;
			next_cycle();
			waited++;
			if (waited > 200) begin
				$display("bus request was never accepted");
				$display("TESTBENCH FAILED");
				$fatal(1);
			end
		end
	endtask

	task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [ARCH_W-1:0] data,
		input logic [SEL_W-1:0] sel);
		pi_req = '{op: PI_WRITE, addr: addr, data: data, sel: sel};
		wait_accept();
		pi_req.op = PI_NOP;
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [ARCH_W-1:0] data);
		pi_req = '{op: PI_READ, addr: addr, data: '0, sel: '1};
		wait_accept();
		data = pi_rsp.data;
		pi_req.op = PI_NOP;
	endtask

	// Counts the cycles soc_rst_o stays high, rdy must be low through them
	task automatic count_reset_cycles(input string name, output int cnt);
		cnt = 0;
		while (soc_rst) begin
			check_bit({name, " rdy low"}, 1'b0, pi_rsp.rdy);
			cnt++;
			next_cycle();
			if (cnt > 1000) begin
				$display("SoC reset did not release in %s", name);
				$display("TESTBENCH FAILED");
				$fatal(1);
			end
		end
		check_bit({name, " rdy high"}, 1'b1, pi_rsp.rdy);
	endtask

	task automatic wait_reset_rise(input string name);
		int n;
		n = 0;
		while (!soc_rst) begin
			next_cycle();
			n++;
			if (n > 20) begin
				$display("software reset never asserted in %s", name);
				$display("TESTBENCH FAILED");
				$fatal(1);
			end
		end
	endtask

	task automatic test_reset_timing();
		int cnt;
		logic [ARCH_W-1:0] rd;
		rst_p = 1'b0;
		// Request waits under back-pressure until the countdown ends
		pi_req = '{op: PI_READ, addr: '0, data: '0, sel: '1};
		count_reset_cycles("reset_timing", cnt);
		check_word("reset_timing count", RST_CYCLES, cnt);
		bus_read('0, rd);
		check_entry("reset_timing first read", expected_entry(0), dev_entry_t'(rd));
	endtask

	task automatic test_dev_table();
		logic [ARCH_W-1:0] rd;
		for (int k = 0; k < 4; k++) begin
			bus_read(ADDR_W'(k), rd);
			check_entry("dev_table entry", expected_entry(k), dev_entry_t'(rd));
		end
		bus_read(30'd5, rd);
		check_word("dev_table offset 5", '0, rd);
	endtask

	task automatic test_ram();
		int idx;
		int addrs[$];
		logic [ARCH_W-1:0] wd;
		logic [SEL_W-1:0] sel;
		for (int i = 0; i < 8; i++) begin
			idx = int'(lcg_next() % RAM_WORDS);
			wd = lcg_next();
			bus_write(RAM_BASE + ADDR_W'(idx), wd, '1);
			ram_model[idx] = wd;
			addrs.push_back(idx);
		end
		// Single byte overwrites merged into the model
		for (int i = 0; i < 4; i++) begin
			idx = addrs[i * 2];
			wd = lcg_next();
			sel = SEL_W'(1 << i);
			bus_write(RAM_BASE + ADDR_W'(idx), wd, sel);
			ram_model[idx][i*8 +: 8] = wd[i*8 +: 8];
		end
		// One read per cycle, data arrives one cycle behind its address
		for (int i = 0; i <= addrs.size(); i++) begin
			if (i > 0) begin
				check_word("ram back_to_back", ram_model[addrs[i-1]], pi_rsp.data);
			end
			if (i < addrs.size()) begin
				pi_req = '{op: PI_READ, addr: RAM_BASE + ADDR_W'(addrs[i]), data: '0, sel: '1};
				check_bit("ram back_to_back rdy", 1'b1, pi_rsp.rdy);
			end else begin
				pi_req.op = PI_NOP;
			end
			next_cycle();
		end
	endtask

	task automatic test_invalid_device();
		logic [ARCH_W-1:0] rd;
		bus_write(RAM_BASE + 30'd5, 32'h5a5a_c3c3, '1);
		ram_model[5] = 32'h5a5a_c3c3;
		bus_read(MAP_END, rd);
		check_word("invalid word 96", '0, rd);
		bus_read(MAP_END + 30'd1, rd);
		check_word("invalid word 97", '0, rd);
		bus_read('1, rd);
		check_word("invalid top word", '0, rd);
		// Would alias RAM word 5 if the decode wrapped
		bus_write(MAP_END + 30'd5, 32'hdead_beef, '1);
		bus_read(RAM_BASE + 30'd5, rd);
		check_word("invalid write ram kept", ram_model[5], rd);
	endtask

	task automatic test_interrupts();
		logic [ARCH_W-1:0] rd;
		irq_src = '1;
		next_cycle();
		irq_src = '0;
		check_bit("irq masked", 1'b0, irq);
		next_cycle();
		check_bit("irq masked later", 1'b0, irq);
		bus_write(INTC_BASE + 30'd1, '1, '1);
		check_bit("irq after enable", 1'b1, irq);
		bus_read(INTC_BASE + 30'd1, rd);
		check_word("irq enable readback", ARCH_W'((1 << INT_SRC_CNT) - 1), rd);
		bus_read(INTC_BASE, rd);
		check_word("irq first claim", 32'd0, rd);
		check_bit("irq still pending", 1'b1, irq);
		bus_read(INTC_BASE, rd);
		check_word("irq second claim", 32'd1, rd);
		check_bit("irq after last claim", 1'b0, irq);
		bus_read(INTC_BASE, rd);
		check_word("irq empty claim", '1, rd);
	endtask

	task automatic test_soft_reset();
		int cnt;
		logic [ARCH_W-1:0] rd;
		bus_write(INTC_BASE + 30'd1, '1, '1);
		bus_write(RAM_BASE + 30'd10, 32'h0bad_f00d, '1);
		ram_model[10] = 32'h0bad_f00d;
		bus_write(CTRL_ADDR, 32'd1, '1);
		wait_reset_rise("warm reset");
		count_reset_cycles("warm reset", cnt);
		check_word("warm reset count", RST_CYCLES, cnt);
		bus_read(INTC_BASE + 30'd1, rd);
		check_word("warm reset enables", '0, rd);
		bus_read(RAM_BASE + 30'd10, rd);
		check_word("warm reset ram kept", ram_model[10], rd);
		bus_write(CTRL_ADDR, 32'd2, '1);
		wait_reset_rise("power off");
		repeat (100) begin
			check_bit("power off hold", 1'b1, soc_rst);
			next_cycle();
		end
		rst_p = 1'b1;
		repeat (4) next_cycle();
		rst_p = 1'b0;
		count_reset_cycles("power off release", cnt);
		check_word("power off release count", RST_CYCLES, cnt);
		bus_read(30'd2, rd);
		check_entry("power off bus alive", expected_entry(2), dev_entry_t'(rd));
	endtask

	initial begin
		lcg_state = 32'd34320;
		rst_p = 1'b1;
		pi_req = '{op: PI_NOP, addr: '0, data: '0, sel: '0};
		irq_src = '0;
		repeat (16) @(posedge clk24mhz);
		#0.5;
		test_reset_timing();
		test_dev_table();
		test_ram();
		test_invalid_device();
		test_interrupts();
		test_soft_reset();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- perint_soc.f
rtl/perint_soc_pkg.sv
rtl/reset_seq.sv
rtl/pi_router.sv
rtl/dev_table.sv
rtl/int_ctrl.sv
rtl/scratch_ram.sv
rtl/perint_soc.sv
verification/perint_soc_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the perint_soc testbench with Verilator and runs it.
# The exit status of the simulation binary is the result of the run.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module perint_soc_tb \
	--Mdir obj_dir \
	-o perint_soc_sim \
	-f perint_soc.f

./obj_dir/perint_soc_sim
